// File: tb.f
+incdir+source
source/wdt_timer_pkg.sv
source/wdt_reg_pkg.sv
source/wdt_reg_decode.sv
source/wdt_core.sv
source/wdt_intr_gen.sv
source/wdt_subsys_top.sv
tests/wdt_tb.sv

// File: Makefile
# Verilator build and run for the watchdog subsystem testbench

VERILATOR ?= verilator
TOP       ?= wdt_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/wdt_tb.sv
// Directed testbench that drives the watchdog host port and checks status and interrupts
`timescale 1ns/1ps
`include "wdt_config.svh"

module wdt_tb;
    import wdt_reg_pkg::*;
    import wdt_timer_pkg::*;

    localparam int CLK_PERIOD = 40;

    logic                   clk;
    logic                   rst_b;
    logic                   reg_wr;
    logic                   reg_rd;
    wdt_reg_e               reg_addr;
    logic [`WDT_DATA_W-1:0] reg_wdata;
    logic [`WDT_DATA_W-1:0] reg_rdata;
    wdt_intr_t              intr;

    int          cycle;
    int          t1_pulses;
    int          t2_pulses;
    int          t1_pulse_cycle;
    int          t2_pulse_cycle;
    int          checks_failed;
    int          timeout_cycles;
    int unsigned p1;
    int unsigned p2;

    wdt_subsys_top dut0 (
        .clk       (clk),
        .rst_b     (rst_b),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .intr      (intr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Free-running cycle count read 2 ns after an edge or at the negedge
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Pulse monitor sampled mid-cycle where intr is stable
    always @(negedge clk) begin
        if (rst_b) begin
            if (intr.t1_timeout_p) begin
                t1_pulses      = t1_pulses + 1;
                t1_pulse_cycle = cycle;
            end
            if (intr.t2_timeout_p) begin
                t2_pulses      = t2_pulses + 1;
                t2_pulse_cycle = cycle;
            end
        end
    end

    // Run limit scales with the random periods
    initial begin
        wait (timeout_cycles != 0);
        #(timeout_cycles * CLK_PERIOD);
        abort_run("Simulation ran past the watchdog time limit");
    end

    task automatic abort_run(input string reason);
        checks_failed = checks_failed + 1;
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_rdata(input string name, input logic [`WDT_DATA_W-1:0] expected,
                               input logic [`WDT_DATA_W-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("error: %s expected 0x%08h got 0x%08h", name, expected, actual));
    endtask

    task automatic check_status(input string name, input wdt_status_t expected,
                                input wdt_status_t actual);
        if (actual !== expected)
            abort_run($sformatf("error: %s expected 0x%0h got 0x%0h", name, expected, actual));
    endtask

    task automatic check_intr(input string name, input wdt_intr_t expected,
                              input wdt_intr_t actual);
        if (actual !== expected)
            abort_run($sformatf("error: %s expected 0x%0h got 0x%0h", name, expected, actual));
    endtask

    function automatic wdt_status_t make_status(input logic fatal, input logic t2, input logic t1);
        wdt_status_t s;
        s.fatal_timeout = fatal;
        s.t2_timeout    = t2;
        s.t1_timeout    = t1;
        return s;
    endfunction

    task automatic apply_reset();
        rst_b = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_b = 1'b1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // One-cycle write strobe that returns 2 ns after the write edge
    task automatic reg_write(input wdt_reg_e addr, input logic [`WDT_DATA_W-1:0] data);
        @(posedge clk);
        #2;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #2;
        reg_wr    = 1'b0;
        reg_wdata = '0;
    endtask

    // Read data is registered and valid right after the strobe edge
    task automatic reg_read(input wdt_reg_e addr, output logic [`WDT_DATA_W-1:0] data);
        @(posedge clk);
        #2;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge clk);
        #2;
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    task automatic read_status(output wdt_status_t s);
        logic [`WDT_DATA_W-1:0] rd;
        reg_read(STATUS, rd);
        check_rdata("reg_rdata[31:3]", '0, {rd[`WDT_DATA_W-1:3], 3'b000});
        s = wdt_status_t'(rd[2:0]);
    endtask

    // Upper period word stays zero for the small test periods
    task automatic program_periods(input int unsigned per1, input int unsigned per2);
        reg_write(T1_PERIOD_LO, per1);
        reg_write(T1_PERIOD_HI, '0);
        reg_write(T2_PERIOD_LO, per2);
        reg_write(T2_PERIOD_HI, '0);
    endtask

    // Wait for one intr bit where 0 is the t1 pulse, 1 the t2 pulse and 2 fatal
    task automatic wait_intr_high(input int idx, input int start, input int limit,
                                  input string name);
        logic [2:0] bits;
        logic       found;
        found = 1'b0;
        while (!found) begin
            @(negedge clk);
            bits = intr;
            if (bits[idx])
                found = 1'b1;
            else if (cycle - start >= limit)
                abort_run($sformatf("%s did not rise within %0d cycles", name, limit));
        end
    endtask

    task automatic test_after_reset();
        logic [`WDT_DATA_W-1:0] w [4];
        logic [`WDT_DATA_W-1:0] rd;
        wdt_status_t            s;
        $display("Running after-reset checks");
        apply_reset();
        check_intr("intr", '0, intr);
        read_status(s);
        check_status("STATUS", make_status(0, 0, 0), s);
        for (int i = 0; i < 4; i++)
            w[i] = $urandom;
        // Timers stay disabled and any period value is harmless
        reg_write(T1_PERIOD_LO, w[0]);
        reg_write(T1_PERIOD_HI, w[1]);
        reg_write(T2_PERIOD_LO, w[2]);
        reg_write(T2_PERIOD_HI, w[3]);
        reg_read(T1_PERIOD_LO, rd);
        check_rdata("T1_PERIOD_LO", w[0], rd);
        reg_read(T1_PERIOD_HI, rd);
        check_rdata("T1_PERIOD_HI", w[1], rd);
        reg_read(T2_PERIOD_LO, rd);
        check_rdata("T2_PERIOD_LO", w[2], rd);
        reg_read(T2_PERIOD_HI, rd);
        check_rdata("T2_PERIOD_HI", w[3], rd);
        check_intr("intr", '0, intr);
    endtask

    task automatic test_independent();
        int          start1;
        int          start2;
        int          base1;
        int          base2;
        wdt_status_t s;
        $display("Running independent mode, p1=%0d p2=%0d", p1, p2);
        apply_reset();
        program_periods(p1, p2);
        base1 = t1_pulses;
        base2 = t2_pulses;
        reg_write(T1_CTRL, 32'h1);
        start1 = cycle;
        reg_write(T2_CTRL, 32'h1);
        start2 = cycle;
        wait_cycles(((p1 > p2) ? p1 : p2) + 6);
        if (t1_pulses - base1 != 1)
            abort_run($sformatf("t1 pulse seen %0d times, expected once", t1_pulses - base1));
        if (t2_pulses - base2 != 1)
            abort_run($sformatf("t2 pulse seen %0d times, expected once", t2_pulses - base2));
        if (t1_pulse_cycle - start1 > int'(p1) + 3)
            abort_run("t1 pulse came later than period plus 3 cycles");
        if (t2_pulse_cycle - start2 > int'(p2) + 3)
            abort_run("t2 pulse came later than period plus 3 cycles");
        read_status(s);
        check_status("STATUS", make_status(0, 1, 1), s);
        check_intr("intr", '0, intr);
    endtask

    // Continues from the independent test with both flags set
    task automatic test_service();
        int          start;
        wdt_status_t s;
        $display("Running service checks");
        reg_write(STATUS, 32'h1);
        start = cycle;
        read_status(s);
        check_status("STATUS", make_status(0, 1, 0), s);
        wait_intr_high(0, start, p1 + 3, "t1 pulse after service");
        if (cycle - start < int'(p1))
            abort_run("t1 pulse after service came before its period");
        read_status(s);
        check_status("STATUS", make_status(0, 1, 1), s);
        reg_write(STATUS, 32'h2);
        start = cycle;
        read_status(s);
        check_status("STATUS", make_status(0, 0, 1), s);
        wait_intr_high(1, start, p2 + 3, "t2 pulse after service");
        if (cycle - start < int'(p2))
            abort_run("t2 pulse after service came before its period");
        read_status(s);
        check_status("STATUS", make_status(0, 1, 1), s);
        check_intr("intr", '0, intr);
    endtask

    task automatic test_restart();
        int          base1;
        int          start;
        int          gap;
        wdt_status_t s;
        $display("Running restart checks, p1=%0d", p1);
        apply_reset();
        program_periods(p1, p2);
        base1 = t1_pulses;
        // Each restart lands before the count can reach the period
        gap = p1 / 2 - 1;
        reg_write(T1_CTRL, 32'h3);
        for (int i = 0; i < 6; i++) begin
            wait_cycles(gap);
            reg_write(T1_CTRL, 32'h3);
        end
        if (t1_pulses != base1)
            abort_run("t1 timed out although restarts came faster than its period");
        read_status(s);
        check_status("STATUS", make_status(0, 0, 0), s);
        // Without restarts the timer must still run out
        start = cycle;
        wait_intr_high(0, start, p1 + 3, "t1 pulse after restarts stop");
    endtask

    task automatic test_cascade();
        int          start;
        int          base2;
        wdt_status_t s;
        wdt_intr_t   exp_intr;
        $display("Running cascade mode, p1=%0d p2=%0d", p1, p2);
        apply_reset();
        program_periods(p1, p2);
        base2 = t2_pulses;
        reg_write(T1_CTRL, 32'h1);
        start = cycle;
        wait_intr_high(0, start, p1 + 3, "t1 pulse in cascade");
        wait_intr_high(2, start, p1 + p2 + 6, "fatal_timeout");
        wait_cycles(p2 + 4);
        if (t2_pulses != base2)
            abort_run("t2 pulse appeared in cascade mode");
        exp_intr = '0;
        exp_intr.fatal_timeout = 1'b1;
        check_intr("intr", exp_intr, intr);
        // Timer 2 reached its period too and its flag is set as well
        read_status(s);
        check_status("STATUS", make_status(1, 1, 1), s);
    endtask

    initial begin
        rst_b          = 1'b0;
        reg_wr         = 1'b0;
        reg_rd         = 1'b0;
        reg_addr       = T1_CTRL;
        reg_wdata      = '0;
        cycle          = 0;
        t1_pulses      = 0;
        t2_pulses      = 0;
        t1_pulse_cycle = 0;
        t2_pulse_cycle = 0;
        checks_failed  = 0;
        timeout_cycles = 0;
        void'($urandom(32'ha5f6));
        p1 = $urandom_range(20, 4);
        p2 = $urandom_range(20, 4);
        timeout_cycles = 4 * int'(p1 + p2) + 400;

        test_after_reset();
        test_independent();
        test_service();
        test_restart();
        test_cascade();

        if (checks_failed == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: source/wdt_subsys_top.sv
// Watchdog subsystem top: register decode, timer core and interrupt generator behind a host port
`timescale 1ns/1ps
`include "wdt_config.svh"

module wdt_subsys_top (
    input  logic                     clk,
    input  logic                     rst_b,
    // Host register port, plain strobes
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  wdt_reg_pkg::wdt_reg_e    reg_addr,
    input  logic [`WDT_DATA_W-1:0]   reg_wdata,
    output logic [`WDT_DATA_W-1:0]   reg_rdata,
    // Timeout interrupts
    output wdt_timer_pkg::wdt_intr_t intr
);
    import wdt_reg_pkg::*;
    import wdt_timer_pkg::*;

    wdt_ctrl_t   ctrl;
    wdt_status_t status;

    // Register file and pulse generation
    wdt_reg_decode u_decode (
        .clk       (clk),
        .rst_b     (rst_b),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .status    (status),
        .reg_rdata (reg_rdata),
        .ctrl      (ctrl)
    );

    // Both timers and the flags
    wdt_core u_core (
        .clk    (clk),
        .rst_b  (rst_b),
        .ctrl   (ctrl),
        .status (status)
    );

    // Timer 2 enable tells the generator which mode is active
    wdt_intr_gen u_intr (
        .clk       (clk),
        .rst_b     (rst_b),
        .status    (status),
        .timer2_en (ctrl.timer2_en),
        .intr      (intr)
    );

endmodule

// File: source/wdt_intr_gen.sv
// Interrupt generator: rising-edge pulses from timeout flags, t2 masked in cascade mode
`timescale 1ns/1ps

module wdt_intr_gen (
    input  logic                       clk,
    input  logic                       rst_b,
    input  wdt_timer_pkg::wdt_status_t status,
    input  logic                       timer2_en,
    output wdt_timer_pkg::wdt_intr_t   intr
);

    logic t1_timeout_q;
    logic t2_timeout_q;

    // Previous-cycle copies of the flags for edge detection
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_timeout_q <= 1'b0;
            t2_timeout_q <= 1'b0;
        end else begin
            t1_timeout_q <= status.t1_timeout;
            t2_timeout_q <= status.t2_timeout;
        end
    end

    always_comb begin
        // First cycle of the t1 flag
        intr.t1_timeout_p  = status.t1_timeout && !t1_timeout_q;
        // Cascade mode reports t2 only through the fatal output
        intr.t2_timeout_p  = status.t2_timeout && !t2_timeout_q && timer2_en;
        intr.fatal_timeout = status.fatal_timeout;
    end

    // Each interrupt pulse lasts a single cycle
    a_t1_single: assert property (
        @(posedge clk) disable iff (!rst_b)
        intr.t1_timeout_p |=> !intr.t1_timeout_p
    );

    a_t2_single: assert property (
        @(posedge clk) disable iff (!rst_b)
        intr.t2_timeout_p |=> !intr.t2_timeout_p
    );

endmodule

// File: source/wdt_core.sv
// Watchdog core: two period counters with independent and cascade modes, and the timeout flags
`timescale 1ns/1ps

module wdt_core (
    input  logic                       clk,
    input  logic                       rst_b,
    input  wdt_reg_pkg::wdt_ctrl_t     ctrl,
    output wdt_timer_pkg::wdt_status_t status
);
    import wdt_timer_pkg::*;

    wdt_period_t t1_count;
    wdt_period_t t2_count;
    logic        cascade;
    logic        t1_run;
    logic        t2_run;
    logic        t1_hit;
    logic        t2_hit;
    logic        t2_clear;

    // Cascade mode: only timer 1 enabled, timer 2 backs it up
    assign cascade = ctrl.timer1_en && !ctrl.timer2_en;

    // Timer 1 runs while enabled and not yet timed out
    assign t1_run = ctrl.timer1_en && !status.t1_timeout;

    // Timer 2 runs on its own enable, or in cascade once timer 1 has expired
    assign t2_run = (ctrl.timer2_en || (cascade && status.t1_timeout)) && !status.t2_timeout;

    // Greater-or-equal so a period lowered mid-count still stops the counter
    assign t1_hit = t1_count >= ctrl.timer1_period;
    assign t2_hit = t2_count >= ctrl.timer2_period;

    // In cascade, servicing timer 1 also restarts the backup count
    assign t2_clear = ctrl.t2_serviced || ctrl.timer2_restart ||
                      (cascade && ctrl.t1_serviced);

    // Timer 1 counter
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_count <= '0;
        end else if (ctrl.t1_serviced || ctrl.timer1_restart) begin
            t1_count <= '0;
        end else if (t1_run && !t1_hit) begin
            t1_count <= t1_count + 1'b1;
        end
    end

    // Timer 2 counter
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t2_count <= '0;
        end else if (t2_clear) begin
            t2_count <= '0;
        end else if (t2_run && !t2_hit) begin
            t2_count <= t2_count + 1'b1;
        end
    end

    // Timeout flags
    // Service wins over a timeout in the same cycle
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            status <= '0;
        end else begin
            if (ctrl.t1_serviced)
                status.t1_timeout <= 1'b0;
            else if (t1_run && t1_hit && !ctrl.timer1_restart)
                status.t1_timeout <= 1'b1;

            if (ctrl.t2_serviced)
                status.t2_timeout <= 1'b0;
            else if (t2_run && t2_hit && !t2_clear)
                status.t2_timeout <= 1'b1;

            // Sticky until reset
            if (cascade && t2_run && t2_hit && !t2_clear)
                status.fatal_timeout <= 1'b1;
        end
    end

    // Fatal only comes out of cascade mode
    a_fatal_in_cascade: assert property (
        @(posedge clk) disable iff (!rst_b)
        $rose(status.fatal_timeout) |-> !$past(ctrl.timer2_en)
    );

    // A counter step never lands past the period it was compared to
    a_t1_in_range: assert property (
        @(posedge clk) disable iff (!rst_b)
        (t1_count > $past(t1_count)) |-> (t1_count <= $past(ctrl.timer1_period))
    );

    a_t2_in_range: assert property (
        @(posedge clk) disable iff (!rst_b)
        (t2_count > $past(t2_count)) |-> (t2_count <= $past(ctrl.timer2_period))
    );

endmodule

// File: source/wdt_reg_decode.sv
// Register decode stage: holds enables, periods and pulse requests, returns read data to the host
`timescale 1ns/1ps
`include "wdt_config.svh"

module wdt_reg_decode (
    input  logic                     clk,
    input  logic                     rst_b,
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  wdt_reg_pkg::wdt_reg_e    reg_addr,
    input  logic [`WDT_DATA_W-1:0]   reg_wdata,
    input  wdt_timer_pkg::wdt_status_t status,
    output logic [`WDT_DATA_W-1:0]   reg_rdata,
    output wdt_reg_pkg::wdt_ctrl_t   ctrl
);
    import wdt_reg_pkg::*;
    import wdt_timer_pkg::*;

    logic                   t1_en;
    logic                   t2_en;
    wdt_period_t            t1_period;
    wdt_period_t            t2_period;
    logic                   t1_restart;
    logic                   t2_restart;
    logic                   t1_service;
    logic                   t2_service;
    int unsigned            word_sel;
    logic [`WDT_DATA_W-1:0] rd_mux;

    // Which period word the address points at
    always_comb begin
        case (reg_addr)
            T1_PERIOD_HI, T2_PERIOD_HI: word_sel = 1;
            default: word_sel = 0;
        endcase
    end

    // Enables and periods update on the write edge
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_en     <= 1'b0;
            t2_en     <= 1'b0;
            t1_period <= '0;
            t2_period <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                T1_CTRL: t1_en <= reg_wdata[0];
                T2_CTRL: t2_en <= reg_wdata[0];
                T1_PERIOD_LO, T1_PERIOD_HI: begin
                    if (word_sel < `WDT_PERIOD_DWORDS)
                        t1_period[word_sel*`WDT_DATA_W +: `WDT_DATA_W] <= reg_wdata;
                end
                T2_PERIOD_LO, T2_PERIOD_HI: begin
                    if (word_sel < `WDT_PERIOD_DWORDS)
                        t2_period[word_sel*`WDT_DATA_W +: `WDT_DATA_W] <= reg_wdata;
                end
                default: ;
            endcase
        end
    end

    // Write-one bits become single-cycle pulses on the next cycle
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_restart <= 1'b0;
            t2_restart <= 1'b0;
            t1_service <= 1'b0;
            t2_service <= 1'b0;
        end else begin
            t1_restart <= reg_wr && (reg_addr == T1_CTRL) && reg_wdata[1];
            t2_restart <= reg_wr && (reg_addr == T2_CTRL) && reg_wdata[1];
            // Writing one to a STATUS bit services that timer
            t1_service <= reg_wr && (reg_addr == STATUS) && reg_wdata[0];
            t2_service <= reg_wr && (reg_addr == STATUS) && reg_wdata[1];
        end
    end

    // Read mux, restart bits always read back as zero
    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            T1_CTRL: rd_mux[0] = t1_en;
            T2_CTRL: rd_mux[0] = t2_en;
            T1_PERIOD_LO, T1_PERIOD_HI:
                rd_mux = t1_period[word_sel*`WDT_DATA_W +: `WDT_DATA_W];
            T2_PERIOD_LO, T2_PERIOD_HI:
                rd_mux = t2_period[word_sel*`WDT_DATA_W +: `WDT_DATA_W];
            STATUS:
                rd_mux[2:0] = {status.fatal_timeout, status.t2_timeout, status.t1_timeout};
            default: ;
        endcase
    end

    // Read data valid the cycle after the strobe, held otherwise
    always_ff @(posedge clk) begin
        if (reg_rd)
            reg_rdata <= rd_mux;
    end

    // Decoded controls to the core
    always_comb begin
        ctrl.timer1_en      = t1_en;
        ctrl.timer2_en      = t2_en;
        ctrl.timer1_restart = t1_restart;
        ctrl.timer2_restart = t2_restart;
        ctrl.timer1_period  = t1_period;
        ctrl.timer2_period  = t2_period;
        ctrl.t1_serviced    = t1_service;
        ctrl.t2_serviced    = t2_service;
    end

    // Host never reads and writes in the same cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (!rst_b) !(reg_wr && reg_rd)
    );

endmodule

// File: source/wdt_reg_pkg.sv
// Register-side types: host register map and the decoded controls fed into the watchdog core
`include "wdt_config.svh"

package wdt_reg_pkg;

    // Register map
    // CTRL bit 0 is enable, bit 1 is restart (write one, self clearing)
    // STATUS bits 0 and 1 are write-one-to-clear, bit 2 is read only
    typedef enum logic [`WDT_ADDR_W-1:0] {
        T1_CTRL      = 4'h0,
        T1_PERIOD_LO = 4'h1,
        T1_PERIOD_HI = 4'h2,
        T2_CTRL      = 4'h3,
        T2_PERIOD_LO = 4'h4,
        T2_PERIOD_HI = 4'h5,
        STATUS       = 4'h6
    } wdt_reg_e;

    // Decoded controls from the register file into the core
    // Restart and service fields are single-cycle pulses
    typedef struct packed {
        // Timer enables, levels
        logic                      timer1_en;
        logic                      timer2_en;
        // Clear the running count
        logic                      timer1_restart;
        logic                      timer2_restart;
        // Timeout periods in clock cycles
        wdt_timer_pkg::wdt_period_t timer1_period;
        wdt_timer_pkg::wdt_period_t timer2_period;
        // Software acknowledged the timeout
        logic                      t1_serviced;
        logic                      t2_serviced;
    } wdt_ctrl_t;

endpackage

// File: source/wdt_timer_pkg.sv
// Timer-side types shared by the watchdog core, the interrupt generator and the register decoder
`include "wdt_config.svh"

package wdt_timer_pkg;

    // One timeout period, spanning WDT_PERIOD_DWORDS host words
    // Also the width of each running counter
    typedef logic [`WDT_PERIOD_W-1:0] wdt_period_t;

    // Timeout flags held by the core
    // All three are levels
    // t1 and t2 clear on service, fatal clears only on reset
    typedef struct packed {
        // Set when the cascade timer 2 runs out
        logic fatal_timeout;
        // Timer 2 reached its period
        logic t2_timeout;
        // Timer 1 reached its period
        logic t1_timeout;
    } wdt_status_t;

    // Interrupt outputs of the subsystem
    // The two timer outputs are one-cycle pulses
    typedef struct packed {
        // Level, straight from the status flag
        logic fatal_timeout;
        // Pulse, suppressed in cascade mode
        logic t2_timeout_p;
        // Pulse on the rising edge of the t1 flag
        logic t1_timeout_p;
    } wdt_intr_t;

endpackage

// File: source/wdt_config.svh
// Build-time sizing for the watchdog subsystem, included by packages, RTL and testbench
`ifndef WDT_CONFIG_SVH
`define WDT_CONFIG_SVH

// Number of 32-bit words that make up one timeout period
`define WDT_PERIOD_DWORDS 2

// Period width in bits
// Each period word is one host data word wide
`define WDT_PERIOD_W (`WDT_PERIOD_DWORDS * 32)

// Register address width
// Leaves room for a few more registers later
`define WDT_ADDR_W 4

// Host data bus width, one 32-bit word
`define WDT_DATA_W 32

`endif
